// File: Makefile
VERILATOR := verilator
TOP       := mem_stage_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
SIMFLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/axi_sram.sv
// single-beat AXI-Lite slave over a word array
// fixed read latency, one write wait cycle, byte strobes

`timescale 1ns/10ps

module axi_sram import memu_pkg::*; (
	input  logic  clk,
	input  logic  reset,

	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,

	output word_t rdata,
	output logic  rvalid,
	input  logic  rready,

	input  addr_t awaddr,
	input  logic  awvalid,
	output logic  awready,
	input  word_t wdata,
	input  strb_t wstrb,
	input  logic  wvalid,
	output logic  wready,

	output logic  bvalid,
	input  logic  bready
);

	word_t mem [SRAM_WORDS];

	logic                       rd_busy;
	logic [WAIT_COUNT_BITS-1:0] rd_count;
	logic [SRAM_INDEX_BITS-1:0] rd_index;
	logic                       rd_fire;
	logic                       rd_done;

	logic                       wr_ready;
	logic [WAIT_COUNT_BITS-1:0] wr_count;
	logic                       wr_fire;

	// one read outstanding at a time
	assign arready = !rd_busy;
	assign rd_fire = arvalid && arready;
	// last wait cycle, data shows up next cycle
	assign rd_done = rd_busy && !rvalid && (rd_count == WAIT_COUNT_BITS'(1));

	// address and data accepted together
	assign awready = wr_ready;
	assign wready  = wr_ready;
	assign wr_fire = wr_ready && awvalid && wvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_busy  <= 1'b0;
			rd_count <= '0;
			rvalid   <= 1'b0;
		end else begin
			if (rd_fire) begin
				rd_busy  <= 1'b1;
				rd_count <= WAIT_COUNT_BITS'(SRAM_READ_LATENCY);
			end else if (rd_done) begin
				rvalid <= 1'b1;
			end else if (rd_busy && !rvalid) begin
				rd_count <= rd_count - 1'b1;
			end
			if (rvalid && rready) begin
				rvalid  <= 1'b0;
				rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ready <= 1'b0;
			wr_count <= '0;
			bvalid   <= 1'b0;
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_fire) begin
				wr_ready <= 1'b0;
				bvalid   <= 1'b1;
			end else if (awvalid && wvalid && !wr_ready && !bvalid) begin
				// hold off ready for the wait cycles
				if (wr_count == WAIT_COUNT_BITS'(SRAM_WRITE_LATENCY - 1)) begin
					wr_ready <= 1'b1;
					wr_count <= '0;
				end else begin
					wr_count <= wr_count + 1'b1;
				end
			end
		end
	end

	// array access, byte-address bits 9 to 2
	always_ff @(posedge clk) begin
		if (rd_fire)
			rd_index <= araddr[SRAM_INDEX_BITS+1:2];
		if (rd_done)
			rdata <= mem[rd_index];
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i])
					mem[awaddr[SRAM_INDEX_BITS+1:2]][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

// File: hw/load_extend.sv
// read-word lane select for loads
// byte and halfword sign or zero extension

`timescale 1ns/10ps

module load_extend import memu_pkg::*; (
	input  word_t      rdata,
	input  logic [1:0] addr_suffix,
	input  load_kind_t load_kind,
	output word_t      value
);

	word_t shifted;

	// addressed lane moved down to bit 0
	assign shifted = rdata >> {addr_suffix, 3'b000};

	always_comb begin
		case (load_kind)
			ld_lb:   value = {{24{shifted[7]}}, shifted[7:0]};
			ld_lbu:  value = {24'h0, shifted[7:0]};
			ld_lh:   value = {{16{shifted[15]}}, shifted[15:0]};
			ld_lhu:  value = {16'h0, shifted[15:0]};
			// lw is always word aligned
			default: value = rdata;
		endcase
	end

endmodule

// File: hw/mem_stage_top.sv
// memory-access stage joined to its SRAM slave
// internal AXI-Lite bus wiring only

`timescale 1ns/10ps

module mem_stage_top import memu_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	input  logic        in_valid,
	output logic        in_ready,
	input  mem_op_t     op,
	input  addr_t       pc,
	input  word_t       alu_result,
	input  word_t       store_data,
	input  load_kind_t  load_kind,
	input  store_size_t store_size,
	input  logic        rd_write,
	input  reg_addr_t   rd_addr,

	output logic        out_valid,
	input  logic        out_ready,
	output addr_t       pc_w,
	output word_t       alu_result_w,
	output logic        rd_write_w,
	output reg_addr_t   rd_addr_w,
	output word_t       load_data,
	output logic        is_load
);

	addr_t araddr;
	addr_t awaddr;
	word_t rdata;
	word_t wdata;
	strb_t wstrb;
	logic  arvalid;
	logic  arready;
	logic  rvalid;
	logic  rready;
	logic  awvalid;
	logic  awready;
	logic  wvalid;
	logic  wready;
	logic  bvalid;
	logic  bready;

	memu u_memu (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.op           (op),
		.pc           (pc),
		.alu_result   (alu_result),
		.store_data   (store_data),
		.load_kind    (load_kind),
		.store_size   (store_size),
		.rd_write     (rd_write),
		.rd_addr      (rd_addr),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.pc_w         (pc_w),
		.alu_result_w (alu_result_w),
		.rd_write_w   (rd_write_w),
		.rd_addr_w    (rd_addr_w),
		.load_data    (load_data),
		.is_load      (is_load),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bvalid       (bvalid),
		.bready       (bready)
	);

	axi_sram u_axi_sram (
		.clk     (clk),
		.reset   (reset),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

// File: hw/memu.sv
// memory-access stage of the in-order core
// latches one instruction, runs one AXI-Lite read or write,
// hands the result to write-back

`timescale 1ns/10ps

module memu import memu_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	// from execute
	input  logic        in_valid,
	output logic        in_ready,
	input  mem_op_t     op,
	input  addr_t       pc,
	input  word_t       alu_result,
	input  word_t       store_data,
	input  load_kind_t  load_kind,
	input  store_size_t store_size,
	input  logic        rd_write,
	input  reg_addr_t   rd_addr,

	// to write-back
	output logic        out_valid,
	input  logic        out_ready,
	output addr_t       pc_w,
	output word_t       alu_result_w,
	output logic        rd_write_w,
	output reg_addr_t   rd_addr_w,
	output word_t       load_data,
	output logic        is_load,

	// read channels
	output addr_t       araddr,
	output logic        arvalid,
	input  logic        arready,
	input  word_t       rdata,
	input  logic        rvalid,
	output logic        rready,

	// write channels
	output addr_t       awaddr,
	output logic        awvalid,
	input  logic        awready,
	output word_t       wdata,
	output strb_t       wstrb,
	output logic        wvalid,
	input  logic        wready,
	input  logic        bvalid,
	output logic        bready
);

	memu_state_t state;

	// latched instruction
	mem_op_t     op_r;
	addr_t       pc_r;
	word_t       alu_result_r;
	word_t       store_data_r;
	load_kind_t  load_kind_r;
	store_size_t store_size_r;
	logic        rd_write_r;
	reg_addr_t   rd_addr_r;
	word_t       load_data_r;

	logic        accept;
	logic [1:0]  addr_suffix;
	word_t       extended;

	assign in_ready    = (state == s_idle);
	assign out_valid   = (state == s_send);
	assign accept      = in_valid && in_ready;
	assign addr_suffix = alu_result_r[1:0];

	// the address is the alu result and stays put while busy
	assign araddr = alu_result_r;
	assign awaddr = alu_result_r;

	load_extend u_load_extend (
		.rdata       (rdata),
		.addr_suffix (addr_suffix),
		.load_kind   (load_kind_r),
		.value       (extended)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= s_idle;
			op_r    <= op_none;
			arvalid <= 1'b0;
			rready  <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			bready  <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (accept) begin
						op_r  <= op;
						state <= (op == op_none) ? s_send : s_lock;
					end
				end
				s_lock: begin
					if (op_r == op_read) begin
						arvalid <= 1'b1;
						state   <= s_read_addr;
					end else begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= s_write_addr;
					end
				end
				s_read_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= s_read_data;
					end
				end
				s_read_data: begin
					if (rvalid) begin
						rready <= 1'b0;
						state  <= s_send;
					end
				end
				s_write_addr: begin
					// slave raises both readies in the same cycle
					if (awready && wready) begin
						awvalid <= 1'b0;
						wvalid  <= 1'b0;
						bready  <= 1'b1;
						state   <= s_write_resp;
					end
				end
				s_write_resp: begin
					if (bvalid) begin
						bready <= 1'b0;
						state  <= s_send;
					end
				end
				s_send: begin
					if (out_ready)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_r         <= pc;
			alu_result_r <= alu_result;
			store_data_r <= store_data;
			load_kind_r  <= load_kind;
			store_size_r <= store_size;
			rd_write_r   <= rd_write;
			rd_addr_r    <= rd_addr;
			load_data_r  <= '0;
		end
		// store data moved onto its byte lanes
		if (state == s_lock) begin
			wdata <= store_data_r << {addr_suffix, 3'b000};
			case (store_size_r)
				sz_sb:   wstrb <= 4'b0001 << addr_suffix;
				sz_sh:   wstrb <= 4'b0011 << addr_suffix;
				default: wstrb <= 4'b1111;
			endcase
		end
		if (state == s_read_data && rvalid)
			load_data_r <= extended;
	end

	assign pc_w         = pc_r;
	assign alu_result_w = alu_result_r;
	assign rd_write_w   = rd_write_r;
	assign rd_addr_w    = rd_addr_r;
	assign load_data    = load_data_r;
	assign is_load      = (op_r == op_read);

endmodule

// File: hw/memu_pkg.sv
// shared types for the memory-access stage
// width typedefs, operation and state enums
// SRAM size and wait-state constants

package memu_pkg;

	// data and address widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  strb_t;

	// access kind from execute
	typedef enum logic [1:0] {
		op_none  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} mem_op_t;

	// load forms
	typedef enum logic [2:0] {
		ld_lb  = 3'd0,
		ld_lbu = 3'd1,
		ld_lh  = 3'd2,
		ld_lhu = 3'd3,
		ld_lw  = 3'd4
	} load_kind_t;

	// store forms
	typedef enum logic [1:0] {
		sz_sb = 2'd0,
		sz_sh = 2'd1,
		sz_sw = 2'd2
	} store_size_t;

	// stage FSM
	typedef enum logic [2:0] {
		s_idle, s_lock, s_read_addr, s_read_data, s_write_addr, s_write_resp, s_send
	} memu_state_t;

	// SRAM geometry, 256 words wraps above 1 KB
	localparam int SRAM_WORDS      = 256;
	localparam int SRAM_INDEX_BITS = $clog2(SRAM_WORDS);

	// wait states, counted in cycles
	localparam int SRAM_READ_LATENCY  = 2;
	localparam int SRAM_WRITE_LATENCY = 1;
	localparam int WAIT_COUNT_BITS    = 2;

endpackage

// File: src.f
hw/memu_pkg.sv
hw/load_extend.sv
hw/memu.sv
hw/axi_sram.sv
hw/mem_stage_top.sv
verif/tb_clock.sv
verif/mem_stage_assertions.sv
verif/mem_stage_tb.sv

// File: verif/mem_stage_assertions.sv
// concurrent checks on the stage handshakes
// output hold under back-pressure, in/out exclusion, one bus request at a time

`timescale 1ns/10ps

module mem_stage_assertions import memu_pkg::*; (
	input logic      clk,
	input logic      reset,
	input logic      in_ready,
	input logic      out_valid,
	input logic      out_ready,
	input addr_t     pc_w,
	input word_t     alu_result_w,
	input logic      rd_write_w,
	input reg_addr_t rd_addr_w,
	input word_t     load_data,
	input logic      is_load,
	input logic      arvalid,
	input logic      awvalid
);

	int fail_count = 0;

	// stalled output holds every field
	property hold_while_stalled;
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(pc_w) && $stable(alu_result_w)
			&& $stable(rd_write_w) && $stable(rd_addr_w) && $stable(load_data)
			&& $stable(is_load));
	endproperty

	hold_check: assert property (hold_while_stalled)
	else begin
		$error("write-back outputs changed while out_ready was low");
		fail_count++;
	end

	in_out_check: assert property (@(posedge clk) disable iff (reset) !(in_ready && out_valid))
	else begin
		$error("in_ready and out_valid high in the same cycle");
		fail_count++;
	end

	bus_check: assert property (@(posedge clk) disable iff (reset) !(arvalid && awvalid))
	else begin
		$error("read and write address requests raised together");
		fail_count++;
	end

endmodule

// File: verif/mem_stage_tb.sv
// testbench for the memory-access stage with its SRAM
// random loads, stores and plain instructions against a byte-array model
// expected-output queue, timeout and result summary

`timescale 1ns/10ps

module mem_stage_tb import memu_pkg::*; ();

	localparam int N_WORD  = 40;
	localparam int N_SUB   = 120;
	localparam int N_NONE  = 40;
	localparam int N_MIXED = 160;
	localparam int N_OPS   = 2 * N_WORD + N_SUB + N_NONE + N_MIXED;
	localparam int TIMEOUT_CYCLES = N_OPS * 12 + 200;

	typedef struct packed {
		addr_t     pc;
		word_t     alu_result;
		logic      rd_write;
		reg_addr_t rd_addr;
		logic      is_load;
		word_t     load_data;
	} expect_t;

	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	mem_op_t     op;
	addr_t       pc;
	word_t       alu_result;
	word_t       store_data;
	load_kind_t  load_kind;
	store_size_t store_size;
	logic        rd_write;
	reg_addr_t   rd_addr;
	logic        out_valid;
	logic        out_ready = 1'b0;
	addr_t       pc_w;
	word_t       alu_result_w;
	logic        rd_write_w;
	reg_addr_t   rd_addr_w;
	word_t       load_data;
	logic        is_load;

	// byte model of the 1 KB SRAM and the words known to hold data
	logic [7:0] model_mem [1024];
	bit         word_written [SRAM_WORDS];
	int         written_words [$];
	expect_t    expected_q [$];

	bit stress = 1'b0;
	int errors = 0;
	int checks = 0;
	int accepted = 0;
	int received = 0;
	int cycles = 0;

	tb_clock u_clock (.clk(clk));

	mem_stage_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.op           (op),
		.pc           (pc),
		.alu_result   (alu_result),
		.store_data   (store_data),
		.load_kind    (load_kind),
		.store_size   (store_size),
		.rd_write     (rd_write),
		.rd_addr      (rd_addr),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.pc_w         (pc_w),
		.alu_result_w (alu_result_w),
		.rd_write_w   (rd_write_w),
		.rd_addr_w    (rd_addr_w),
		.load_data    (load_data),
		.is_load      (is_load)
	);

	bind memu mem_stage_assertions u_memu_checks (
		.clk          (clk),
		.reset        (reset),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.pc_w         (pc_w),
		.alu_result_w (alu_result_w),
		.rd_write_w   (rd_write_w),
		.rd_addr_w    (rd_addr_w),
		.load_data    (load_data),
		.is_load      (is_load),
		.arvalid      (arvalid),
		.awvalid      (awvalid)
	);

	task automatic compare_value(string what, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	// little-endian read of the model with load-form extension
	function automatic word_t model_load(addr_t a, load_kind_t k);
		logic [9:0]  i;
		logic [15:0] half;
		i = a[9:0];
		half = {model_mem[i + 10'd1], model_mem[i]};
		case (k)
			ld_lb:   return {{24{model_mem[i][7]}}, model_mem[i]};
			ld_lbu:  return {24'h0, model_mem[i]};
			ld_lh:   return {{16{half[15]}}, half};
			ld_lhu:  return {16'h0, half};
			default: return {model_mem[i + 10'd3], model_mem[i + 10'd2], half};
		endcase
	endfunction

	task automatic model_store(addr_t a, store_size_t s, word_t d);
		int n;
		n = (s == sz_sb) ? 1 : (s == sz_sh) ? 2 : 4;
		for (int b = 0; b < n; b++)
			model_mem[a[9:0] + 10'(b)] = d[8*b +: 8];
	endtask

	// aligned address inside a word that already holds data
	function automatic addr_t pick_addr(int align);
		int w;
		int off;
		w = written_words[$urandom_range(0, written_words.size() - 1)];
		off = $urandom_range(0, 3) & ~(align - 1);
		return addr_t'(w * 4 + off);
	endfunction

	function automatic addr_t new_word_addr();
		int w;
		w = $urandom_range(0, SRAM_WORDS - 1);
		if (!word_written[w]) begin
			word_written[w] = 1'b1;
			written_words.push_back(w);
		end
		return addr_t'(w * 4);
	endfunction

	task automatic run_op(mem_op_t o, load_kind_t lk, store_size_t ss, addr_t a);
		expect_t   e;
		int        gap;
		addr_t     pc_v;
		word_t     alu_v;
		word_t     data_v;
		logic      rdw;
		reg_addr_t rda;
		gap = stress ? $urandom_range(0, 3) : 0;
		pc_v = addr_t'($urandom) & ~32'h3;
		alu_v = (o == op_none) ? word_t'($urandom) : a;
		data_v = $urandom;
		rdw = 1'($urandom_range(0, 1));
		rda = reg_addr_t'($urandom_range(0, 31));
		repeat (gap) @(posedge clk);
		@(posedge clk);
		in_valid   <= 1'b1;
		op         <= o;
		pc         <= pc_v;
		alu_result <= alu_v;
		store_data <= data_v;
		load_kind  <= lk;
		store_size <= ss;
		rd_write   <= rdw;
		rd_addr    <= rda;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		// accepted at the coming edge, so the model steps here
		e.pc = pc_v;
		e.alu_result = alu_v;
		e.rd_write = rdw;
		e.rd_addr = rda;
		e.is_load = (o == op_read);
		e.load_data = (o == op_read) ? model_load(a, lk) : '0;
		if (o == op_write)
			model_store(a, ss, data_v);
		expected_q.push_back(e);
		accepted++;
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic do_load(load_kind_t k);
		int align;
		align = (k == ld_lw) ? 4 : (k == ld_lh || k == ld_lhu) ? 2 : 1;
		run_op(op_read, k, store_size_t'($urandom_range(0, 2)), pick_addr(align));
	endtask

	// fresh words only come from sw so every loaded byte is known
	task automatic do_store(store_size_t s, bit fresh);
		addr_t a;
		int    align;
		align = (s == sz_sw) ? 4 : (s == sz_sh) ? 2 : 1;
		a = fresh ? new_word_addr() : pick_addr(align);
		run_op(op_write, load_kind_t'($urandom_range(0, 4)), s, a);
	endtask

	task automatic drain();
		while (expected_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic finish_test(string name, int err_before, int ops);
		drain();
		$display("test %s: %0d instructions, %0d errors", name, ops, errors - err_before);
	endtask

	always @(posedge clk)
		out_ready <= stress ? ($urandom_range(0, 3) != 0) : 1'b1;

	// output transfers land on the next rising edge
	always @(negedge clk) begin
		expect_t seen;
		if (!reset && out_valid && out_ready) begin
			received++;
			if (expected_q.size() == 0) begin
				$display("unexpected output at %0t ns with no instruction pending", $time);
				errors++;
			end else begin
				seen = expected_q.pop_front();
				compare_value("pc_w", pc_w, seen.pc);
				compare_value("alu_result_w", alu_result_w, seen.alu_result);
				compare_value("rd_write_w", 32'(rd_write_w), 32'(seen.rd_write));
				compare_value("rd_addr_w", 32'(rd_addr_w), 32'(seen.rd_addr));
				compare_value("is_load", 32'(is_load), 32'(seen.is_load));
				if (seen.is_load)
					compare_value("load_data", load_data, seen.load_data);
			end
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int err0;
		void'($urandom(32'hd25ff6ee));
		reset      = 1'b1;
		in_valid   = 1'b0;
		op         = op_none;
		pc         = '0;
		alu_result = '0;
		store_data = '0;
		load_kind  = ld_lw;
		store_size = sz_sw;
		rd_write   = 1'b0;
		rd_addr    = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		err0 = errors;
		compare_value("out_valid after reset", 32'(out_valid), 32'h0);
		compare_value("in_ready after reset", 32'(in_ready), 32'h1);
		$display("test 1 reset state: %0d errors", errors - err0);

		err0 = errors;
		for (int i = 0; i < N_WORD; i++)
			do_store(sz_sw, 1'b1);
		for (int i = 0; i < N_WORD; i++)
			do_load(ld_lw);
		finish_test("2 word store and load", err0, 2 * N_WORD);

		err0 = errors;
		for (int i = 0; i < N_SUB; i++) begin
			case ($urandom_range(0, 6))
				0:       do_store(sz_sb, 1'b0);
				1:       do_store(sz_sh, 1'b0);
				2:       do_load(ld_lb);
				3:       do_load(ld_lbu);
				4:       do_load(ld_lh);
				5:       do_load(ld_lhu);
				default: do_load(ld_lw);
			endcase
		end
		finish_test("3 byte and halfword access", err0, N_SUB);

		err0 = errors;
		for (int i = 0; i < N_NONE; i++)
			run_op(op_none, load_kind_t'($urandom_range(0, 4)),
				store_size_t'($urandom_range(0, 2)), '0);
		finish_test("4 no-memory pass-through", err0, N_NONE);

		err0 = errors;
		stress = 1'b1;
		for (int i = 0; i < N_MIXED; i++) begin
			case ($urandom_range(0, 9))
				0, 1:    run_op(op_none, ld_lw, sz_sw, '0);
				2:       do_store(sz_sw, 1'b1);
				3:       do_store(sz_sb, 1'b0);
				4:       do_store(sz_sh, 1'b0);
				5:       do_store(sz_sw, 1'b0);
				default: do_load(load_kind_t'($urandom_range(0, 4)));
			endcase
		end
		finish_test("5 mixed with gaps and back-pressure", err0, N_MIXED);
		stress = 1'b0;

		// quiet window to catch a stray output after the last instruction
		repeat (16) @(posedge clk);
		compare_value("instructions out vs accepted", received, accepted);
		$display("summary: %0d accepted, %0d out, %0d checks, %0d errors, %0d assertion failures",
			accepted, received, checks, errors, dut0.u_memu.u_memu_checks.fail_count);
		if (errors == 0 && dut0.u_memu.u_memu_checks.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
// free-running testbench clock
// 8 ns period, starts low

`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	// half period of 4 ns
	always #4 clk = ~clk;

endmodule
